// ==== common/uv_pkg.sv ====
package uv_pkg;

    // ----------------------------------------
    // Pixels and blocks
    // ----------------------------------------

    typedef logic [7:0] pixel_t;

    // One chroma block word
    // planes[0] is U, planes[1] is V, raster order inside a plane
    // pix[16*p + r] is the same byte as planes[p][r]
    typedef union packed {
        pixel_t [1:0][15:0] planes;
        pixel_t [31:0]      pix;
    } uv_block_u;

    typedef logic signed [11:0] level_t;

    typedef level_t [31:0] levels_t;

    // Neighbours, element 0 is the leftmost or topmost pixel
    typedef struct packed {
        pixel_t [3:0] top_u;
        pixel_t [3:0] top_v;
        pixel_t [3:0] left_u;
        pixel_t [3:0] left_v;
        pixel_t       top_left_u;
        pixel_t       top_left_v;
    } neigh_t;

    typedef struct packed {
        logic [15:0] q;
        logic [15:0] iq;
        logic [15:0] bias;
    } quant_t;

    // ----------------------------------------
    // Modes and scoring
    // ----------------------------------------

    typedef enum logic [1:0] {
        dc    = 2'd0,
        vert  = 2'd1,
        horiz = 2'd2,
        tm    = 2'd3
    } uv_mode_e;

    // Header cost per mode, indexed by uv_mode_e
    localparam logic [3:0][15:0] FIXED_COST = {16'd642, 16'd439, 16'd984, 16'd302};

    typedef logic [63:0] score_t;

endpackage

// ==== pred/uv_predictor.sv ====
module uv_predictor (
    input  uv_pkg::neigh_t          neigh,
    output uv_pkg::uv_block_u [3:0] pred
);
    import uv_pkg::*;

    pixel_t [1:0][3:0] top;
    pixel_t [1:0][3:0] left;
    pixel_t [1:0]      top_left;
    pixel_t [1:0]      dc_val;

    // Plane 0 is U, plane 1 is V
    assign top      = {neigh.top_v, neigh.top_u};
    assign left     = {neigh.left_v, neigh.left_u};
    assign top_left = {neigh.top_left_v, neigh.top_left_u};

    // ----------------------------------------
    // DC, rounded mean of top and left
    // ----------------------------------------

    always_comb begin
        logic [10:0] sum;
        for (int p = 0; p < 2; p++) begin
            sum = 11'd4;
            for (int k = 0; k < 4; k++) begin
                sum = sum + 11'(top[p][k]) + 11'(left[p][k]);
            end
            dc_val[p] = 8'(sum >> 3);
        end
    end

    // ----------------------------------------
    // All four modes, both planes
    // ----------------------------------------

    always_comb begin
        logic signed [9:0] tm_val;
        for (int p = 0; p < 2; p++) begin
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    pred[dc].planes[p][4*r+c]    = dc_val[p];
                    pred[vert].planes[p][4*r+c]  = top[p][c];
                    pred[horiz].planes[p][4*r+c] = left[p][r];

                    // left + top - corner, then clip
                    tm_val = $signed({2'b00, left[p][r]}) + $signed({2'b00, top[p][c]})
                             - $signed({2'b00, top_left[p]});
                    if (tm_val < 0) begin
                        pred[tm].planes[p][4*r+c] = 8'd0;
                    end else if (tm_val > 10'sd255) begin
                        pred[tm].planes[p][4*r+c] = 8'd255;
                    end else begin
                        pred[tm].planes[p][4*r+c] = tm_val[7:0];
                    end
                end
            end
        end
    end

endmodule

// ==== recon/uv_quantizer.sv ====
module uv_quantizer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rec_start,
    input  uv_pkg::uv_block_u src,
    input  uv_pkg::uv_block_u pred,
    input  uv_pkg::quant_t    quant,
    output uv_pkg::uv_block_u recon,
    output uv_pkg::levels_t   rec_levels,
    output logic [1:0]        rec_nz,
    output logic              rec_done
);
    import uv_pkg::*;

    uv_block_u  recon_c;
    levels_t    levels_c;
    logic [1:0] nz_c;

    // ----------------------------------------
    // Quantize and rebuild, all 32 pixels
    // ----------------------------------------

    always_comb begin
        logic signed [8:0]  diff;
        logic [7:0]         abs_d;
        logic [24:0]        scaled;
        logic [24:0]        mag;
        level_t             lvl;
        logic signed [31:0] rv;
        nz_c = '0;
        for (int i = 0; i < 32; i++) begin
            diff  = $signed({1'b0, src.pix[i]}) - $signed({1'b0, pred.pix[i]});
            abs_d = diff[8] ? 8'(-diff) : diff[7:0];

            scaled = 25'(abs_d) * 25'(quant.iq) + 25'(quant.bias);
            mag    = scaled >> 16;
            // Saturate to the level range
            if (mag > 25'd2047) begin
                mag = 25'd2047;
            end
            lvl = diff[8] ? -level_t'(mag[11:0]) : level_t'(mag[11:0]);
            levels_c[i] = lvl;

            if (lvl != '0) begin
                nz_c[i / 16] = 1'b1;
            end

            rv = 32'(signed'({1'b0, pred.pix[i]})) + 32'(lvl) * 32'(signed'({1'b0, quant.q}));
            if (rv < 0) begin
                recon_c.pix[i] = 8'd0;
            end else if (rv > 32'sd255) begin
                recon_c.pix[i] = 8'd255;
            end else begin
                recon_c.pix[i] = rv[7:0];
            end
        end
    end

    // ----------------------------------------
    // Output registers
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rec_start) begin
            recon      <= recon_c;
            rec_levels <= levels_c;
            rec_nz     <= nz_c;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rec_done <= 1'b0;
        end else begin
            rec_done <= rec_start;
        end
    end

    // Step sizes come from the top level inputs
    assert property (@(posedge clk) disable iff (!rst_n)
        rec_start |-> (quant.q != '0) && (quant.iq != '0))
        else $error("zero quantizer step or inverse at rec_start");

endmodule

// ==== rtl/uv_sse_engine.sv ====
module uv_sse_engine #(
    parameter int PIX_PER_CYCLE = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  uv_pkg::uv_block_u a,
    input  uv_pkg::uv_block_u b,
    output logic [31:0]       sse,
    output logic              done
);
    import uv_pkg::*;

    localparam int STEPS = 32 / PIX_PER_CYCLE;
    localparam int CW    = (STEPS > 1) ? $clog2(STEPS) : 1;

    logic          busy;
    logic [CW-1:0] cnt;
    logic [31:0]   part;

    // Squared error of the current group
    always_comb begin
        pixel_t pa;
        pixel_t pb;
        int     d;
        part = '0;
        for (int k = 0; k < PIX_PER_CYCLE; k++) begin
            pa   = a.pix[int'(cnt) * PIX_PER_CYCLE + k];
            pb   = b.pix[int'(cnt) * PIX_PER_CYCLE + k];
            d    = int'(pa) - int'(pb);
            part = part + 32'(d * d);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
            sse  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
                sse  <= '0;
            end else if (busy) begin
                sse <= sse + part;
                cnt <= cnt + CW'(1);
                if (cnt == CW'(STEPS - 1)) begin
                    busy <= 1'b0;
                    cnt  <= '0;
                    done <= 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("sse done held for two cycles");

endmodule

// ==== rtl/uv_cost_engine.sv ====
module uv_cost_engine #(
    parameter int PIX_PER_CYCLE = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  uv_pkg::levels_t levels,
    output logic [31:0]     cost_sum,
    output logic            done
);
    import uv_pkg::*;

    localparam int STEPS = 32 / PIX_PER_CYCLE;
    localparam int CW    = (STEPS > 1) ? $clog2(STEPS) : 1;

    logic          busy;
    logic [CW-1:0] cnt;
    logic [31:0]   part;

    // Magnitude plus one per nonzero level
    always_comb begin
        level_t lvl;
        int     v;
        part = '0;
        for (int k = 0; k < PIX_PER_CYCLE; k++) begin
            lvl  = levels[int'(cnt) * PIX_PER_CYCLE + k];
            v    = int'(lvl);
            v    = (v < 0) ? -v : v;
            part = part + 32'(v) + ((v != 0) ? 32'd1 : 32'd0);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            cnt      <= '0;
            cost_sum <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                cnt      <= '0;
                cost_sum <= '0;
            end else if (busy) begin
                cost_sum <= cost_sum + part;
                cnt      <= cnt + CW'(1);
                if (cnt == CW'(STEPS - 1)) begin
                    busy <= 1'b0;
                    cnt  <= '0;
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/uv_mode_picker.sv ====
module uv_mode_picker (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic [31:0]       lambda,
    input  logic [31:0]       sse,
    input  logic [31:0]       cost_sum,
    input  logic              sse_done,
    input  logic              cost_done,
    input  uv_pkg::uv_block_u recon,
    input  uv_pkg::levels_t   rec_levels,
    input  logic [1:0]        rec_nz,
    output logic              rec_start,
    output uv_pkg::uv_mode_e  pred_sel,
    output uv_pkg::uv_block_u out,
    output uv_pkg::levels_t   levels,
    output logic [1:0]        nz,
    output uv_pkg::uv_mode_e  mode,
    output logic              done
);
    import uv_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_issue,
        st_wait,
        st_score,
        st_finish
    } state_e;

    state_e     state;
    uv_mode_e   cur;
    logic       sse_seen;
    logic       cost_seen;
    logic [31:0] sse_q;
    logic [31:0] cost_q;

    score_t     cand_score;
    score_t     best_score;
    logic       take_best;
    uv_block_u  best_out;
    levels_t    best_levels;
    logic [1:0] best_nz;
    uv_mode_e   best_mode;

    assign pred_sel = cur;

    // (cost * 1024 + header) * lambda + 256 * sse
    assign cand_score = ((score_t'(cost_q) << 10) + score_t'(FIXED_COST[cur]))
                        * score_t'(lambda) + (score_t'(sse_q) << 8);

    // dc always seeds the best
    assign take_best = (cur == dc) || (cand_score < best_score);

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            cur       <= dc;
            rec_start <= 1'b0;
            sse_seen  <= 1'b0;
            cost_seen <= 1'b0;
            out       <= '0;
            levels    <= '0;
            nz        <= '0;
            mode      <= dc;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        cur   <= dc;
                        state <= st_issue;
                    end
                end
                st_issue: begin
                    rec_start <= 1'b1;
                    sse_seen  <= 1'b0;
                    cost_seen <= 1'b0;
                    state     <= st_wait;
                end
                st_wait: begin
                    rec_start <= 1'b0;
                    if (sse_done) begin
                        sse_seen <= 1'b1;
                    end
                    if (cost_done) begin
                        cost_seen <= 1'b1;
                    end
                    // Engines may finish in either order
                    if ((sse_seen || sse_done) && (cost_seen || cost_done)) begin
                        state <= st_score;
                    end
                end
                st_score: begin
                    if (cur == tm) begin
                        state <= st_finish;
                    end else begin
                        cur   <= uv_mode_e'(cur + 2'd1);
                        state <= st_issue;
                    end
                end
                st_finish: begin
                    out    <= best_out;
                    levels <= best_levels;
                    nz     <= best_nz;
                    mode   <= best_mode;
                    done   <= 1'b1;
                    state  <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Latched engine results and best candidate
    always_ff @(posedge clk) begin
        if (state == st_wait && sse_done) begin
            sse_q <= sse;
        end
        if (state == st_wait && cost_done) begin
            cost_q <= cost_sum;
        end
        if (state == st_score && take_best) begin
            best_score  <= cand_score;
            best_out    <= recon;
            best_levels <= rec_levels;
            best_nz     <= rec_nz;
            best_mode   <= cur;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) start |-> state == st_idle)
        else $error("start received while mode decision busy");

endmodule

// ==== rtl/uv_mode_top.sv ====
module uv_mode_top #(
    parameter int PIX_PER_CYCLE = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  uv_pkg::uv_block_u src,
    input  uv_pkg::neigh_t    neigh,
    input  uv_pkg::quant_t    quant,
    input  logic [31:0]       lambda,
    output uv_pkg::uv_block_u out,
    output uv_pkg::levels_t   levels,
    output logic [1:0]        nz,
    output uv_pkg::uv_mode_e  mode,
    output logic              done
);
    import uv_pkg::*;

    uv_block_u [3:0] pred;
    uv_mode_e        pred_sel;
    logic            rec_start;
    logic            rec_done;
    uv_block_u       recon;
    levels_t         rec_levels;
    logic [1:0]      rec_nz;
    logic [31:0]     sse;
    logic            sse_done;
    logic [31:0]     cost_sum;
    logic            cost_done;

    uv_predictor i_pred (
        .neigh (neigh),
        .pred  (pred)
    );

    uv_quantizer i_quant (
        .clk        (clk),
        .rst_n      (rst_n),
        .rec_start  (rec_start),
        .src        (src),
        .pred       (pred[pred_sel]),
        .quant      (quant),
        .recon      (recon),
        .rec_levels (rec_levels),
        .rec_nz     (rec_nz),
        .rec_done   (rec_done)
    );

    // Both engines start together on rec_done
    uv_sse_engine #(.PIX_PER_CYCLE(PIX_PER_CYCLE)) i_sse (
        .clk   (clk),
        .rst_n (rst_n),
        .start (rec_done),
        .a     (src),
        .b     (recon),
        .sse   (sse),
        .done  (sse_done)
    );

    uv_cost_engine #(.PIX_PER_CYCLE(PIX_PER_CYCLE)) i_cost (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (rec_done),
        .levels   (rec_levels),
        .cost_sum (cost_sum),
        .done     (cost_done)
    );

    uv_mode_picker i_picker (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .lambda     (lambda),
        .sse        (sse),
        .cost_sum   (cost_sum),
        .sse_done   (sse_done),
        .cost_done  (cost_done),
        .recon      (recon),
        .rec_levels (rec_levels),
        .rec_nz     (rec_nz),
        .rec_start  (rec_start),
        .pred_sel   (pred_sel),
        .out        (out),
        .levels     (levels),
        .nz         (nz),
        .mode       (mode),
        .done       (done)
    );

endmodule

// ==== tests/tb_uv_mode.sv ====
module tb_uv_mode;
    import uv_pkg::*;

    localparam int NUM_RANDOM = 40;
    localparam int NUM_BLOCKS = NUM_RANDOM + 4;
    localparam int MAX_CYCLES = NUM_BLOCKS * 4 * 40 + 400;

    logic        clk;
    logic        rst_n;
    logic        start;
    uv_block_u   src;
    neigh_t      neigh;
    quant_t      quant;
    logic [31:0] lambda;
    uv_block_u   out;
    levels_t     levels;
    logic [1:0]  nz;
    uv_mode_e    mode;
    logic        done;

    int          seed;
    int          cycles;
    int          start_count;
    int          done_count;

    uv_block_u   exp_out;
    levels_t     exp_levels;
    logic [1:0]  exp_nz;
    uv_mode_e    exp_mode;

    uv_mode_top #(.PIX_PER_CYCLE(4)) i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .src    (src),
        .neigh  (neigh),
        .quant  (quant),
        .lambda (lambda),
        .out    (out),
        .levels (levels),
        .nz     (nz),
        .mode   (mode),
        .done   (done)
    );

    always #2 clk = ~clk;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    function automatic int clip255(input int v);
        return (v < 0) ? 0 : ((v > 255) ? 255 : v);
    endfunction

    function automatic longint unsigned header_cost(input int m);
        case (m)
            0:       return 64'd302;
            1:       return 64'd984;
            2:       return 64'd439;
            default: return 64'd642;
        endcase
    endfunction

    function automatic uv_block_u predict(input neigh_t n, input int m);
        uv_block_u b;
        int        t [2][4];
        int        l [2][4];
        int        tl [2];
        int        dcv;
        int        v;
        b = '0;
        for (int k = 0; k < 4; k++) begin
            t[0][k] = int'(n.top_u[k]);
            t[1][k] = int'(n.top_v[k]);
            l[0][k] = int'(n.left_u[k]);
            l[1][k] = int'(n.left_v[k]);
        end
        tl[0] = int'(n.top_left_u);
        tl[1] = int'(n.top_left_v);
        for (int p = 0; p < 2; p++) begin
            dcv = 4;
            for (int k = 0; k < 4; k++) begin
                dcv = dcv + t[p][k] + l[p][k];
            end
            dcv = dcv / 8;
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    case (m)
                        0:       v = dcv;
                        1:       v = t[p][c];
                        2:       v = l[p][r];
                        default: v = clip255(l[p][r] + t[p][c] - tl[p]);
                    endcase
                    b.planes[p][4*r+c] = 8'(v);
                end
            end
        end
        return b;
    endfunction

    task automatic compute_expected(input uv_block_u s, input neigh_t n, input quant_t qt,
                                    input logic [31:0] lam);
        uv_block_u       p;
        uv_block_u       r;
        levels_t         lv;
        logic [1:0]      z;
        longint unsigned sse;
        longint unsigned cost;
        longint unsigned score;
        longint unsigned best;
        int              d;
        int              lvl;
        int              rv;
        best = '0;
        for (int m = 0; m < 4; m++) begin
            p    = predict(n, m);
            r    = '0;
            lv   = '0;
            z    = '0;
            sse  = '0;
            cost = '0;
            for (int i = 0; i < 32; i++) begin
                d   = int'(s.pix[i]) - int'(p.pix[i]);
                lvl = ((d < 0 ? -d : d) * int'(qt.iq) + int'(qt.bias)) / 65536;
                lvl = (d < 0) ? -lvl : lvl;
                lvl = (lvl > 2047) ? 2047 : ((lvl < -2048) ? -2048 : lvl);
                lv[i] = level_t'(lvl);
                if (lvl != 0) begin
                    z[i / 16] = 1'b1;
                end
                rv = clip255(int'(p.pix[i]) + lvl * int'(qt.q));
                r.pix[i] = 8'(rv);
                sse  = sse + 64'((int'(s.pix[i]) - rv) * (int'(s.pix[i]) - rv));
                cost = cost + 64'((lvl < 0) ? -lvl : lvl) + ((lvl != 0) ? 64'd1 : 64'd0);
            end
            score = (cost * 64'd1024 + header_cost(m)) * 64'(lam) + sse * 64'd256;
            // Ties keep the earlier, lower mode
            if (m == 0 || score < best) begin
                best       = score;
                exp_out    = r;
                exp_levels = lv;
                exp_nz     = z;
                exp_mode   = uv_mode_e'(2'(m));
            end
        end
    endtask

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    task automatic report_mismatch(input string name, input logic [383:0] expv,
                                   input logic [383:0] actv);
        $display("ERROR at %0t: %s expected %0h actual %0h", $time, name, expv, actv);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s mismatch", name);
    endtask

    task automatic check_outputs();
        assert (mode == exp_mode) else report_mismatch("mode", 384'(exp_mode), 384'(mode));
        assert (out == exp_out) else report_mismatch("out", 384'(exp_out), 384'(out));
        assert (levels == exp_levels)
            else report_mismatch("levels", 384'(exp_levels), 384'(levels));
        assert (nz == exp_nz) else report_mismatch("nz", 384'(exp_nz), 384'(nz));
    endtask

    task automatic check_directed(input uv_mode_e want);
        assert (mode == want) else report_mismatch("mode", 384'(want), 384'(mode));
        assert (levels == '0) else report_mismatch("levels", 384'(0), 384'(levels));
        assert (nz == 2'b00) else report_mismatch("nz", 384'(0), 384'(nz));
        assert (out == src) else report_mismatch("out", 384'(src), 384'(out));
    endtask

    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            $display("done stayed high for more than one cycle");
            $display("TESTBENCH FAILED");
            $fatal(1, "done pulse too long");
        end

    assert property (@(posedge clk) disable iff (!rst_n) done |-> mode == exp_mode)
        else report_mismatch("mode", 384'(exp_mode), 384'(mode));

    // Results may only move together with done
    assert property (@(posedge clk) disable iff (!rst_n)
        !done |-> $stable(out) && $stable(levels) && $stable(nz) && $stable(mode))
        else begin
            $display("outputs changed without a done pulse");
            $display("TESTBENCH FAILED");
            $fatal(1, "outputs not held");
        end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout waiting for done");
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    always @(negedge clk) begin
        if (done) begin
            done_count = done_count + 1;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    task automatic run_block(input uv_block_u s, input neigh_t n, input quant_t qt,
                             input logic [31:0] lam);
        // New inputs while the previous result still holds
        src    = s;
        neigh  = n;
        quant  = qt;
        lambda = lam;
        compute_expected(s, n, qt, lam);
        repeat (2) @(negedge clk);
        start = 1'b1;
        start_count = start_count + 1;
        @(negedge clk);
        start = 1'b0;
        while (!done) begin
            @(negedge clk);
        end
        check_outputs();
        @(negedge clk);
    endtask

    function automatic neigh_t make_neigh(input pixel_t [3:0] top, input pixel_t [3:0] left,
                                          input pixel_t corner);
        neigh_t n;
        n.top_u      = top;
        n.top_v      = top;
        n.left_u     = left;
        n.left_v     = left;
        n.top_left_u = corner;
        n.top_left_v = corner;
        return n;
    endfunction

    // Source is an exact prediction and the coarse step leaves error on the others
    task automatic directed_block(input uv_mode_e want, input neigh_t n);
        quant_t qt;
        qt.q    = 16'd32;
        qt.iq   = 16'd2048;
        qt.bias = 16'd0;
        run_block(predict(n, int'(want)), n, qt, 32'd0);
        check_directed(want);
    endtask

    task automatic random_block();
        neigh_t    n;
        quant_t    qt;
        uv_block_u s;
        uv_block_u base;
        int        pick;
        int        noise;
        int        q;
        for (int k = 0; k < 4; k++) begin
            n.top_u[k]  = 8'($random(seed));
            n.top_v[k]  = 8'($random(seed));
            n.left_u[k] = 8'($random(seed));
            n.left_v[k] = 8'($random(seed));
        end
        n.top_left_u = 8'($random(seed));
        n.top_left_v = 8'($random(seed));
        // 0..3 is a noisy prediction, 4 is pure noise
        pick = {$random(seed)} % 5;
        base = predict(n, pick);
        for (int i = 0; i < 32; i++) begin
            noise = {$random(seed)} % 15;
            if (pick == 4) begin
                s.pix[i] = 8'($random(seed));
            end else begin
                s.pix[i] = 8'(clip255(int'(base.pix[i]) + noise - 7));
            end
        end
        q       = {$random(seed)} % 48;
        q       = q + 1;
        qt.q    = 16'(q);
        qt.iq   = (q == 1) ? 16'hffff : 16'(65536 / q);
        qt.bias = 16'($random(seed));
        run_block(s, n, qt, 32'({$random(seed)} % 128));
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        start       = 1'b0;
        src         = '0;
        neigh       = '0;
        quant       = {16'd1, 16'hffff, 16'd0};
        lambda      = '0;
        seed        = 32'h32b4_a55e;
        cycles      = 0;
        start_count = 0;
        done_count  = 0;
        exp_out     = '0;
        exp_levels  = '0;
        exp_nz      = '0;
        exp_mode    = dc;

        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        assert (done == 1'b0 && out == '0 && levels == '0 && nz == 2'b00 && mode == dc)
            else begin
                $display("outputs not cleared after reset");
                $display("TESTBENCH FAILED");
                $fatal(1, "reset values wrong");
            end

        directed_block(vert, make_neigh({8'd203, 8'd141, 8'd77, 8'd13}, {4{8'd50}}, 8'd90));
        directed_block(horiz, make_neigh({4{8'd50}}, {8'd203, 8'd141, 8'd77, 8'd13}, 8'd90));
        directed_block(dc, make_neigh({8'd203, 8'd141, 8'd77, 8'd13},
                                      {8'd100, 8'd80, 8'd60, 8'd40}, 8'd70));
        // Flat neighbours give four equal predictions and equal scores
        directed_block(dc, make_neigh({4{8'd120}}, {4{8'd120}}, 8'd120));

        for (int b = 0; b < NUM_RANDOM; b++) begin
            random_block();
        end

        if (done_count == start_count) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("done count %0d does not match start count %0d", done_count, start_count);
            $display("TESTBENCH FAILED");
            $fatal(1, "done count mismatch");
        end
    end

endmodule

// ==== sim.f ====
common/uv_pkg.sv
pred/uv_predictor.sv
recon/uv_quantizer.sv
rtl/uv_sse_engine.sv
rtl/uv_cost_engine.sv
rtl/uv_mode_picker.sv
rtl/uv_mode_top.sv
tests/tb_uv_mode.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_uv_mode
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
